// ==== dcpl_stream_pkg.sv ====
// Stream widths and decoupler enable shared by the shell side and the user side.
// Keep width is always derived from the data width. Only whole bytes are supported.
package dcpl_stream_pkg;

  // Default data width of both stream directions.
  localparam int unsigned AXI_DATA_BITS = 64;

  // One keep bit per data byte.
  localparam int unsigned AXI_KEEP_BITS = AXI_DATA_BITS / 8;

  // 1 blocks valid/ready on decouple. 0 turns each decoupler into a pass-through,
  // while the packet gates still track boundaries and report status.
  localparam int unsigned EN_DCPL_DEFAULT = 1;

endpackage

// ==== dcpl_csr_pkg.sv ====
// Register map of the decoupling block. Four 32-bit words on a 2-bit word address.
// CTRL and STATUS share the per-direction bit layout.
package dcpl_csr_pkg;

  // Register data width.
  localparam int unsigned CSR_DATA_BITS = 32;

  // Word address, no byte lanes.
  typedef logic [1:0] csr_addr_t;

  // Register map.
  localparam csr_addr_t CSR_CTRL     = 2'd0; // Decouple requests, read/write.
  localparam csr_addr_t CSR_STATUS   = 2'd1; // Live decouple state, read only.
  localparam csr_addr_t CSR_H2C_PKTS = 2'd2; // h2c packet count, write clears.
  localparam csr_addr_t CSR_C2H_PKTS = 2'd3; // c2h packet count, write clears.

  // Bit positions in CTRL and STATUS.
  localparam int unsigned CTRL_H2C_BIT = 0; // Host-to-card direction.
  localparam int unsigned CTRL_C2H_BIT = 1; // Card-to-host direction.

endpackage

// ==== axis_decoupler_static.sv ====
`timescale 1ns/1ps
// Combinational stage, no buffering. While decouple is high, beats wait upstream.
// EN_DCPL = 0 gives a straight pass-through and decouple is ignored.
module axis_decoupler_static
  import dcpl_stream_pkg::*;
#(
  parameter int unsigned DATA_BITS = AXI_DATA_BITS,
  parameter int unsigned EN_DCPL   = EN_DCPL_DEFAULT
) (
  input  logic                   decouple,

  // Slave side, from the producer.
  input  logic                   s_tvalid,
  output logic                   s_tready,
  input  logic [DATA_BITS-1:0]   s_tdata,
  input  logic [DATA_BITS/8-1:0] s_tkeep,
  input  logic                   s_tlast,

  // Master side, toward the consumer.
  output logic                   m_tvalid,
  input  logic                   m_tready,
  output logic [DATA_BITS-1:0]   m_tdata,
  output logic [DATA_BITS/8-1:0] m_tkeep,
  output logic                   m_tlast
);

  if (EN_DCPL == 1) begin : g_dcpl
    // Handshake blocked in both directions while decoupled.
    assign m_tvalid = decouple ? 1'b0 : s_tvalid; // Hide beats from consumer.
    assign s_tready = decouple ? 1'b0 : m_tready; // Stall producer.

    // Payload always forwarded, qualified by m_tvalid.
    assign m_tdata = s_tdata;
    assign m_tkeep = s_tkeep;
    assign m_tlast = s_tlast;
  end else begin : g_bypass
    // Plain wire-through.
    assign m_tvalid = s_tvalid;
    assign s_tready = m_tready; // Back-pressure straight through.
    assign m_tdata  = s_tdata;
    assign m_tkeep  = s_tkeep;
    assign m_tlast  = s_tlast;
  end

endmodule

// ==== axis_dcpl_gate.sv ====
`timescale 1ns/1ps
// Observes the decoupler slave handshake only. Not in the data path.
// Requests are held off until the current packet has been accepted in full.
module axis_dcpl_gate
  import dcpl_stream_pkg::*;
#(
  parameter int unsigned DATA_BITS = AXI_DATA_BITS
) (
  input  logic aclk,
  input  logic arst_n,

  // Decouple request from the register block.
  input  logic req,

  // Observed slave-side handshake of the decoupler.
  input  logic s_tvalid,
  input  logic s_tready,
  input  logic s_tlast,

  output logic decouple, // Effective decouple, also reported as status.
  output logic pkt_done  // One cycle per accepted tlast beat.
);

  logic beat_acc; // Beat transfers this cycle.
  logic in_pkt;   // Between first and last beat of a packet.

  // Byte-granular keep is assumed along the whole path.
  if ((DATA_BITS % 8) != 0) begin : g_width_chk
    $error("stream data width must be a multiple of 8");
  end

  assign beat_acc = s_tvalid && s_tready;

  // Packet tracking.
  // Set by a non-last beat, cleared by the last one.
  // Single-beat packets never set it.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      in_pkt <= 1'b0;
    end else if (beat_acc) begin
      in_pkt <= !s_tlast;
    end
  end

  // Request takes effect only at a packet boundary.
  // Release is immediate since req drops straight through.
  assign decouple = req && !in_pkt;

  // Completed packet, counted by the register block.
  assign pkt_done = beat_acc && s_tlast;

  // A rising decouple means the stream was idle or its last beat just went through.
  a_boundary: assert property (
    @(posedge aclk) disable iff (!arst_n)
    $rose(decouple) |-> (!$past(in_pkt) || $past(beat_acc && s_tlast))
  ) else $error("decouple rose inside a packet");

  // A presented beat must stay until accepted, or the packet flag loses track.
  a_valid_hold: assert property (
    @(posedge aclk) disable iff (!arst_n)
    (s_tvalid && !s_tready) |=> (s_tvalid && $stable(s_tlast))
  ) else $error("source dropped or changed a beat before acceptance");

endmodule

// ==== dcpl_csr.sv ====
`timescale 1ns/1ps
// Plain strobe register port: one-cycle write, read data one cycle after csr_rd.
// Counters wrap at 32 bits. Writing a counter address clears it, STATUS ignores writes.
module dcpl_csr
  import dcpl_csr_pkg::*;
(
  input  logic                     aclk,
  input  logic                     arst_n,

  // Register port.
  input  logic                     csr_wr,
  input  logic                     csr_rd,
  input  csr_addr_t                csr_addr,
  input  logic [CSR_DATA_BITS-1:0] csr_wdata,
  output logic [CSR_DATA_BITS-1:0] csr_rdata,
  output logic                     csr_rvalid,

  // Requests to the packet gates.
  output logic                     dcpl_req_h2c,
  output logic                     dcpl_req_c2h,

  // Effective decouple from the gates.
  input  logic                     dcpl_h2c,
  input  logic                     dcpl_c2h,

  // Completed-packet pulses.
  input  logic                     pkt_done_h2c,
  input  logic                     pkt_done_c2h
);

  logic [1:0]               ctrl_q;     // Decouple request bits.
  logic [CSR_DATA_BITS-1:0] h2c_pkts_q; // Packets passed, h2c.
  logic [CSR_DATA_BITS-1:0] c2h_pkts_q; // Packets passed, c2h.
  logic [CSR_DATA_BITS-1:0] status_w;   // Live status word.
  logic [CSR_DATA_BITS-1:0] rd_word;    // Selected read value.
  logic                     wr_ctrl;
  logic                     clr_h2c;
  logic                     clr_c2h;

  // Write decode.
  assign wr_ctrl = csr_wr && (csr_addr == CSR_CTRL);
  assign clr_h2c = csr_wr && (csr_addr == CSR_H2C_PKTS);
  assign clr_c2h = csr_wr && (csr_addr == CSR_C2H_PKTS);

  // Control register, visible on the requests the next cycle.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= 2'b00; // Nothing decoupled out of reset.
    end else if (wr_ctrl) begin
      ctrl_q[CTRL_H2C_BIT] <= csr_wdata[CTRL_H2C_BIT];
      ctrl_q[CTRL_C2H_BIT] <= csr_wdata[CTRL_C2H_BIT];
    end
  end

  assign dcpl_req_h2c = ctrl_q[CTRL_H2C_BIT];
  assign dcpl_req_c2h = ctrl_q[CTRL_C2H_BIT];

  // Packet counters. Clear wins over a same-cycle packet.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      h2c_pkts_q <= '0;
      c2h_pkts_q <= '0;
    end else begin
      if (clr_h2c) begin
        h2c_pkts_q <= '0;
      end else if (pkt_done_h2c) begin
        h2c_pkts_q <= h2c_pkts_q + 1'b1; // Wraps.
      end
      if (clr_c2h) begin
        c2h_pkts_q <= '0;
      end else if (pkt_done_c2h) begin
        c2h_pkts_q <= c2h_pkts_q + 1'b1;
      end
    end
  end

  // Status reflects the gates directly, not the requests.
  always_comb begin
    status_w               = '0;
    status_w[CTRL_H2C_BIT] = dcpl_h2c;
    status_w[CTRL_C2H_BIT] = dcpl_c2h;
  end

  // Read select.
  always_comb begin
    case (csr_addr)
      CSR_CTRL:     rd_word = {{(CSR_DATA_BITS-2){1'b0}}, ctrl_q};
      CSR_STATUS:   rd_word = status_w;
      CSR_H2C_PKTS: rd_word = h2c_pkts_q; // Value before any same-cycle clear.
      default:      rd_word = c2h_pkts_q;
    endcase
  end

  // Read valid, one cycle after the strobe.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      csr_rvalid <= 1'b0;
    end else begin
      csr_rvalid <= csr_rd;
    end
  end

  // Read data, only meaningful with csr_rvalid.
  always_ff @(posedge aclk) begin
    if (csr_rd) begin
      csr_rdata <= rd_word;
    end
  end

  // Every read answers in the next cycle, and only reads do.
  a_rd_resp: assert property (
    @(posedge aclk) disable iff (!arst_n)
    csr_rd |=> csr_rvalid
  ) else $error("read strobe without response");

  a_rd_only: assert property (
    @(posedge aclk) disable iff (!arst_n)
    csr_rvalid |-> $past(csr_rd)
  ) else $error("read response without strobe");

endmodule

// ==== dcpl_top.sv ====
`timescale 1ns/1ps
// Shell-to-user decoupling for both stream directions plus the register block.
// Decouple requests wait for packet boundaries. No buffering, no tuser or tid.
module dcpl_top
  import dcpl_stream_pkg::*;
  import dcpl_csr_pkg::*;
#(
  parameter int unsigned DATA_BITS = AXI_DATA_BITS,
  parameter int unsigned EN_DCPL   = EN_DCPL_DEFAULT
) (
  input  logic                     aclk,
  input  logic                     arst_n,

  // h2c slave stream, from the shell.
  input  logic                     h2c_s_tvalid,
  output logic                     h2c_s_tready,
  input  logic [DATA_BITS-1:0]     h2c_s_tdata,
  input  logic [DATA_BITS/8-1:0]   h2c_s_tkeep,
  input  logic                     h2c_s_tlast,

  // h2c master stream, to the user region.
  output logic                     h2c_m_tvalid,
  input  logic                     h2c_m_tready,
  output logic [DATA_BITS-1:0]     h2c_m_tdata,
  output logic [DATA_BITS/8-1:0]   h2c_m_tkeep,
  output logic                     h2c_m_tlast,

  // c2h slave stream, from the user region.
  input  logic                     c2h_s_tvalid,
  output logic                     c2h_s_tready,
  input  logic [DATA_BITS-1:0]     c2h_s_tdata,
  input  logic [DATA_BITS/8-1:0]   c2h_s_tkeep,
  input  logic                     c2h_s_tlast,

  // c2h master stream, to the shell.
  output logic                     c2h_m_tvalid,
  input  logic                     c2h_m_tready,
  output logic [DATA_BITS-1:0]     c2h_m_tdata,
  output logic [DATA_BITS/8-1:0]   c2h_m_tkeep,
  output logic                     c2h_m_tlast,

  // Register port.
  input  logic                     csr_wr,
  input  logic                     csr_rd,
  input  csr_addr_t                csr_addr,
  input  logic [CSR_DATA_BITS-1:0] csr_wdata,
  output logic [CSR_DATA_BITS-1:0] csr_rdata,
  output logic                     csr_rvalid
);

  logic dcpl_req_h2c; // Requests from CTRL.
  logic dcpl_req_c2h;
  logic dcpl_h2c;     // Effective decouple, also STATUS.
  logic dcpl_c2h;
  logic pkt_done_h2c; // Completed-packet pulses.
  logic pkt_done_c2h;

  dcpl_csr u_csr (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .csr_wr       (csr_wr),
    .csr_rd       (csr_rd),
    .csr_addr     (csr_addr),
    .csr_wdata    (csr_wdata),
    .csr_rdata    (csr_rdata),
    .csr_rvalid   (csr_rvalid),
    .dcpl_req_h2c (dcpl_req_h2c),
    .dcpl_req_c2h (dcpl_req_c2h),
    .dcpl_h2c     (dcpl_h2c),
    .dcpl_c2h     (dcpl_c2h),
    .pkt_done_h2c (pkt_done_h2c),
    .pkt_done_c2h (pkt_done_c2h)
  );

  // h2c direction. Gate watches the decoupler slave side.
  axis_dcpl_gate #(.DATA_BITS(DATA_BITS)) u_gate_h2c (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .req      (dcpl_req_h2c),
    .s_tvalid (h2c_s_tvalid),
    .s_tready (h2c_s_tready),
    .s_tlast  (h2c_s_tlast),
    .decouple (dcpl_h2c),
    .pkt_done (pkt_done_h2c)
  );

  axis_decoupler_static #(.DATA_BITS(DATA_BITS), .EN_DCPL(EN_DCPL)) u_dcpl_h2c (
    .decouple (dcpl_h2c),
    .s_tvalid (h2c_s_tvalid),
    .s_tready (h2c_s_tready),
    .s_tdata  (h2c_s_tdata),
    .s_tkeep  (h2c_s_tkeep),
    .s_tlast  (h2c_s_tlast),
    .m_tvalid (h2c_m_tvalid),
    .m_tready (h2c_m_tready),
    .m_tdata  (h2c_m_tdata),
    .m_tkeep  (h2c_m_tkeep),
    .m_tlast  (h2c_m_tlast)
  );

  // c2h direction, same arrangement.
  axis_dcpl_gate #(.DATA_BITS(DATA_BITS)) u_gate_c2h (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .req      (dcpl_req_c2h),
    .s_tvalid (c2h_s_tvalid),
    .s_tready (c2h_s_tready),
    .s_tlast  (c2h_s_tlast),
    .decouple (dcpl_c2h),
    .pkt_done (pkt_done_c2h)
  );

  axis_decoupler_static #(.DATA_BITS(DATA_BITS), .EN_DCPL(EN_DCPL)) u_dcpl_c2h (
    .decouple (dcpl_c2h),
    .s_tvalid (c2h_s_tvalid),
    .s_tready (c2h_s_tready),
    .s_tdata  (c2h_s_tdata),
    .s_tkeep  (c2h_s_tkeep),
    .s_tlast  (c2h_s_tlast),
    .m_tvalid (c2h_m_tvalid),
    .m_tready (c2h_m_tready),
    .m_tdata  (c2h_m_tdata),
    .m_tkeep  (c2h_m_tkeep),
    .m_tlast  (c2h_m_tlast)
  );

endmodule

// ==== tb_dcpl_top.sv ====
`timescale 1ns/1ps
// Stream arrays use index 0 for h2c and index 1 for c2h. DUT runs with EN_DCPL = 1.
// Expected output equals accepted input in order, since the decoupler holds no beats.
module tb_dcpl_top
  import dcpl_stream_pkg::*;
  import dcpl_csr_pkg::*;
();

  localparam int unsigned DATA_BITS   = AXI_DATA_BITS;
  localparam int unsigned KEEP_BITS   = DATA_BITS / 8;
  localparam int unsigned BEAT_BITS   = DATA_BITS + KEEP_BITS + 1; // {last, keep, data}.
  localparam int          TIMEOUT_CYC = 2000;
  localparam int          NUM_PKTS    = 24;

  logic aclk = 1'b0;
  logic arst_n;
  logic                     csr_wr;
  logic                     csr_rd;
  csr_addr_t                csr_addr;
  logic [CSR_DATA_BITS-1:0] csr_wdata;
  logic [CSR_DATA_BITS-1:0] csr_rdata;
  logic                     csr_rvalid;

  logic                 s_tvalid [2] = '{default: 1'b0};
  logic                 s_tready [2];
  logic [DATA_BITS-1:0] s_tdata  [2] = '{default: '0};
  logic [KEEP_BITS-1:0] s_tkeep  [2] = '{default: '0};
  logic                 s_tlast  [2] = '{default: 1'b0};
  logic                 m_tvalid [2];
  logic                 m_tready [2] = '{default: 1'b0};
  logic [DATA_BITS-1:0] m_tdata  [2];
  logic [KEEP_BITS-1:0] m_tkeep  [2];
  logic                 m_tlast  [2];

  logic [BEAT_BITS-1:0]     src_q [2][$]; // Beats waiting to be sent.
  logic [BEAT_BITS-1:0]     exp_q [2][$]; // Accepted, not yet seen at the output.
  logic [CSR_DATA_BITS-1:0] out_cnt    [2] = '{default: '0};
  logic [CSR_DATA_BITS-1:0] model_pkts [2] = '{default: '0}; // tlast beats accepted.
  logic [31:0] rng = 32'h54b;
  logic gaps_on  = 1'b0; // Random idle cycles between source beats.
  logic rdy_rand = 1'b0; // Random sink back-pressure.
  int   err_cnt  = 0;
  int   test_cnt = 0;
  int   fail_cnt = 0;
  int   test_err_base = 0;

  always #4 aclk = ~aclk; // 8 ns period.

  dcpl_top #(.DATA_BITS(DATA_BITS), .EN_DCPL(1)) u_dut (
    .aclk         (aclk),         .arst_n       (arst_n),
    .h2c_s_tvalid (s_tvalid[0]),  .h2c_s_tready (s_tready[0]),
    .h2c_s_tdata  (s_tdata[0]),   .h2c_s_tkeep  (s_tkeep[0]),  .h2c_s_tlast (s_tlast[0]),
    .h2c_m_tvalid (m_tvalid[0]),  .h2c_m_tready (m_tready[0]),
    .h2c_m_tdata  (m_tdata[0]),   .h2c_m_tkeep  (m_tkeep[0]),  .h2c_m_tlast (m_tlast[0]),
    .c2h_s_tvalid (s_tvalid[1]),  .c2h_s_tready (s_tready[1]),
    .c2h_s_tdata  (s_tdata[1]),   .c2h_s_tkeep  (s_tkeep[1]),  .c2h_s_tlast (s_tlast[1]),
    .c2h_m_tvalid (m_tvalid[1]),  .c2h_m_tready (m_tready[1]),
    .c2h_m_tdata  (m_tdata[1]),   .c2h_m_tkeep  (m_tkeep[1]),  .c2h_m_tlast (m_tlast[1]),
    .csr_wr       (csr_wr),       .csr_rd       (csr_rd),      .csr_addr    (csr_addr),
    .csr_wdata    (csr_wdata),    .csr_rdata    (csr_rdata),   .csr_rvalid  (csr_rvalid)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic string dir_name(input int d);
    return (d == 0) ? "h2c" : "c2h";
  endfunction

  // Reference model. Every accepted source beat must leave in order.
  function automatic void model_accept(input int d, input logic [BEAT_BITS-1:0] beat);
    exp_q[d].push_back(beat);
    if (beat[BEAT_BITS-1]) begin
      model_pkts[d]++; // Expected counter value.
    end
  endfunction

  function automatic void gen_packet(input int d, input int len);
    logic [DATA_BITS-1:0] data;
    logic [31:0]          r;
    for (int b = 0; b < len; b++) begin
      for (int i = 0; i < DATA_BITS; i += 32) begin
        data[i +: 32] = next_rand();
      end
      r = next_rand();
      src_q[d].push_back({(b == len - 1), r[KEEP_BITS-1:0], data});
    end
  endfunction

  task automatic check_beat(input int d, input logic [DATA_BITS-1:0] data,
                            input logic [KEEP_BITS-1:0] keep, input logic last,
                            input logic [BEAT_BITS-1:0] exp);
    if (data !== exp[DATA_BITS-1:0]) begin
      $display("ERROR %s_m_tdata got %h exp %h", dir_name(d), data, exp[DATA_BITS-1:0]);
      err_cnt++;
    end
    if (keep !== exp[DATA_BITS +: KEEP_BITS]) begin
      $display("ERROR %s_m_tkeep got %h exp %h", dir_name(d), keep,
               exp[DATA_BITS +: KEEP_BITS]);
      err_cnt++;
    end
    if (last !== exp[BEAT_BITS-1]) begin
      $display("ERROR %s_m_tlast got %h exp %h", dir_name(d), last, exp[BEAT_BITS-1]);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s got %h exp %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input logic [CSR_DATA_BITS-1:0] got,
                             input logic [CSR_DATA_BITS-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h exp %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // Sources and sinks. A presented beat holds until accepted.
  always @(posedge aclk) begin
    logic taken;
    if (arst_n) begin
      for (int d = 0; d < 2; d++) begin
        taken = s_tvalid[d] && s_tready[d];
        if (taken) begin
          void'(src_q[d].pop_front());
        end
        if (!s_tvalid[d] || taken) begin
          if (src_q[d].size() > 0 && (!gaps_on || (next_rand() % 32'd4) != 32'd0)) begin
            {s_tlast[d], s_tkeep[d], s_tdata[d]} <= src_q[d][0];
            s_tvalid[d] <= 1'b1;
          end else begin
            s_tvalid[d] <= 1'b0;
          end
        end
        m_tready[d] <= rdy_rand ? ((next_rand() % 32'd3) != 32'd0) : 1'b1;
      end
    end
  end

  // Comparator. Input side pushes, output side pops in the same cycle.
  always @(posedge aclk) begin
    logic [BEAT_BITS-1:0] exp_b;
    if (arst_n) begin
      for (int d = 0; d < 2; d++) begin
        if (s_tvalid[d] && s_tready[d]) begin
          model_accept(d, {s_tlast[d], s_tkeep[d], s_tdata[d]});
        end
        if (m_tvalid[d] && m_tready[d]) begin
          out_cnt[d]++;
          if (exp_q[d].size() == 0) begin
            $display("%s output beat appeared with no accepted input beat", dir_name(d));
            err_cnt++;
          end else begin
            exp_b = exp_q[d].pop_front();
            check_beat(d, m_tdata[d], m_tkeep[d], m_tlast[d], exp_b);
          end
        end
      end
    end
  end

  task automatic csr_write(input csr_addr_t addr, input logic [CSR_DATA_BITS-1:0] data);
    @(posedge aclk);
    csr_wr    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge aclk);
    csr_wr <= 1'b0;
  endtask

  // Returns the data and the cycles from the sampled strobe to csr_rvalid.
  task automatic csr_read(input csr_addr_t addr, output logic [CSR_DATA_BITS-1:0] data,
                          output int lat);
    logic got;
    got  = 1'b0;
    lat  = 0;
    data = '0;
    @(posedge aclk);
    csr_rd   <= 1'b1;
    csr_addr <= addr;
    @(posedge aclk);
    csr_rd <= 1'b0;
    check_flag("csr_rvalid", csr_rvalid, 1'b0); // No response yet.
    for (int i = 1; i <= TIMEOUT_CYC && !got; i++) begin
      @(posedge aclk);
      if (csr_rvalid) begin
        got  = 1'b1;
        lat  = i;
        data = csr_rdata;
      end
    end
    if (!got) begin
      abort_run($sformatf("no csr_rvalid after a read of address %0d", addr));
    end
  endtask

  task automatic check_csr(input csr_addr_t addr, input logic [CSR_DATA_BITS-1:0] exp);
    logic [CSR_DATA_BITS-1:0] got;
    int lat;
    csr_read(addr, got, lat);
    if (lat != 1) begin
      $display("ERROR csr_rvalid latency got %h exp %h", lat, 1);
      err_cnt++;
    end
    if (got !== exp) begin
      $display("ERROR csr_rdata at address %h got %h exp %h", addr, got, exp);
      err_cnt++;
    end
  endtask

  task automatic wait_drain(input int d);
    logic done;
    done = 1'b0;
    for (int i = 0; i < TIMEOUT_CYC && !done; i++) begin
      @(posedge aclk);
      done = (src_q[d].size() == 0) && !s_tvalid[d];
    end
    if (!done) begin
      abort_run($sformatf("%s source did not drain in %0d cycles", dir_name(d), TIMEOUT_CYC));
    end
  endtask

  task automatic wait_outputs(input int d, input logic [CSR_DATA_BITS-1:0] target);
    logic done;
    done = 1'b0;
    for (int i = 0; i < TIMEOUT_CYC && !done; i++) begin
      @(posedge aclk);
      done = (out_cnt[d] >= target);
    end
    if (!done) begin
      abort_run($sformatf("%s output beats stopped before %0d", dir_name(d), target));
    end
  endtask

  task automatic wait_status(input int unsigned bit_pos);
    logic [CSR_DATA_BITS-1:0] word;
    int   lat;
    logic done;
    done = 1'b0;
    for (int i = 0; i < 64 && !done; i++) begin
      csr_read(CSR_STATUS, word, lat);
      done = word[bit_pos];
    end
    if (!done) begin
      abort_run("status bit never went high after the decouple request");
    end
  endtask

  task automatic check_empty(input int d);
    if (exp_q[d].size() != 0) begin
      $display("%s lost %0d accepted beats", dir_name(d), exp_q[d].size());
      err_cnt++;
    end
  endtask

  task automatic check_blocked(input int d, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge aclk);
      check_flag($sformatf("%s_m_tvalid", dir_name(d)), m_tvalid[d], 1'b0);
      check_flag($sformatf("%s_s_tready", dir_name(d)), s_tready[d], 1'b0);
    end
    check_flag($sformatf("%s_s_tvalid", dir_name(d)), s_tvalid[d], 1'b1); // Beat held.
  endtask

  initial begin
    logic [CSR_DATA_BITS-1:0] base;
    arst_n    = 1'b0;
    csr_wr    = 1'b0;
    csr_rd    = 1'b0;
    csr_addr  = CSR_CTRL;
    csr_wdata = '0;
    repeat (2) @(posedge aclk);
    arst_n <= 1'b1;

    gaps_on  = 1'b1;
    rdy_rand = 1'b1;
    for (int p = 0; p < NUM_PKTS; p++) begin
      gen_packet(0, int'(next_rand() % 32'd8) + 1);
      gen_packet(1, int'(next_rand() % 32'd8) + 1);
    end
    wait_drain(0);
    wait_drain(1);
    check_empty(0);
    check_empty(1);
    end_test("pass-through");

    gaps_on = 1'b0;
    csr_write(CSR_CTRL, 32'h3);
    check_csr(CSR_STATUS, 32'h3); // Idle streams decouple at once.
    gen_packet(0, 3);
    gen_packet(1, 3);
    for (int d = 0; d < 2; d++) begin
      check_blocked(d, 6);
    end
    csr_write(CSR_CTRL, 32'h2); // c2h stays held for the release test.
    wait_drain(0);
    end_test("idle decouple");

    rdy_rand = 1'b0;
    base = out_cnt[0];
    gen_packet(0, 6);
    gen_packet(0, 2); // Beat 7 onward must be held.
    wait_outputs(0, base + 32'd2);
    csr_write(CSR_CTRL, 32'h3);
    wait_status(CTRL_H2C_BIT);
    check_count("h2c beats before decouple", out_cnt[0] - base, 32'd6);
    check_blocked(0, 10);
    check_count("h2c beats while decoupled", out_cnt[0] - base, 32'd6);
    end_test("mid-packet request");

    csr_write(CSR_CTRL, 32'h0);
    gaps_on  = 1'b1;
    rdy_rand = 1'b1;
    wait_drain(0);
    wait_drain(1);
    check_empty(0);
    check_empty(1);
    check_csr(CSR_STATUS, 32'h0);
    end_test("release");

    check_csr(CSR_H2C_PKTS, model_pkts[0]);
    check_csr(CSR_C2H_PKTS, model_pkts[1]);
    csr_write(CSR_H2C_PKTS, 32'hffff_ffff);
    csr_write(CSR_C2H_PKTS, 32'h1234_5678);
    check_csr(CSR_H2C_PKTS, 32'h0);
    check_csr(CSR_C2H_PKTS, 32'h0);
    end_test("counters");

    csr_write(CSR_CTRL, 32'h2);
    check_csr(CSR_CTRL, 32'h2);
    check_csr(CSR_STATUS, 32'h2);
    csr_write(CSR_STATUS, 32'hffff_ffff); // Read only.
    check_csr(CSR_STATUS, 32'h2);
    check_csr(CSR_CTRL, 32'h2);
    csr_write(CSR_CTRL, 32'hffff_fffd); // Upper bits not stored.
    check_csr(CSR_CTRL, 32'h1);
    csr_write(CSR_CTRL, 32'h0);
    check_csr(CSR_STATUS, 32'h0);
    end_test("register access");

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
dcpl_stream_pkg.sv
dcpl_csr_pkg.sv
axis_decoupler_static.sv
axis_dcpl_gate.sv
dcpl_csr.sv
dcpl_top.sv
tb_dcpl_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then decide from the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcpl_top -f tb.f -o sim_tb

# The log decides pass or fail, so a nonzero simulator exit must not stop the script here.
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
